// ==== bbc_glue_pkg.sv ====
package bbc_glue_pkg;

	//==========================================================================
	// core bus and loader types
	//==========================================================================

	// bit 18 picks ram over rom
	typedef logic [18:0] mem_addr_t;
	typedef logic [7:0] mem_byte_t;
	// high byte is the even address
	typedef logic [15:0] rom_word_t;
	typedef logic [16:0] rom_waddr_t;

	// signed mouse accumulator
	typedef logic signed [8:0] axis_t;
	// analog channel as seen by the core adc
	typedef logic [11:0] stick_t;

	// per-report delta limit
	localparam int MOUSE_STEP_MAX = 10;
	localparam int AXIS_MIN = -128;
	localparam int AXIS_MAX = 127;

	// addr 17:14 picks a 16 KB slot
	localparam int ROM_SLOT_BITS = 4;

	// 14 banks of 8K words
	localparam int DEF_ROM_WORDS = 114688;
	localparam int DEF_RAM_DEPTH = 212992;

	typedef struct packed {
		logic valid;
		logic [3:0] bank;
	} rom_map_t;

	//==========================================================================
	// slot to physical bank map
	//==========================================================================

	function automatic rom_map_t rom_bank_of(input logic m128,
			input logic [ROM_SLOT_BITS-1:0] slot);
		rom_map_t map;
		map = '{valid: 1'b0, bank: 4'd0};
		case ({m128, slot})
			// model b: mos, filing system, sideways ram util, basic
			5'b0_0100: map = '{valid: 1'b1, bank: 4'd0};
			5'b0_1000: map = '{valid: 1'b1, bank: 4'd1};
			5'b0_1110: map = '{valid: 1'b1, bank: 4'd2};
			5'b0_1111: map = '{valid: 1'b1, bank: 4'd3};
			// master, banks follow slot order
			5'b1_0010: map = '{valid: 1'b1, bank: 4'd4};
			5'b1_0011: map = '{valid: 1'b1, bank: 4'd5};
			5'b1_0100: map = '{valid: 1'b1, bank: 4'd6};
			5'b1_1001: map = '{valid: 1'b1, bank: 4'd7};
			5'b1_1010: map = '{valid: 1'b1, bank: 4'd8};
			5'b1_1011: map = '{valid: 1'b1, bank: 4'd9};
			5'b1_1100: map = '{valid: 1'b1, bank: 4'd10};
			5'b1_1101: map = '{valid: 1'b1, bank: 4'd11};
			5'b1_1110: map = '{valid: 1'b1, bank: 4'd12};
			5'b1_1111: map = '{valid: 1'b1, bank: 4'd13};
			// empty slot, reads as zero
			default: map = '{valid: 1'b0, bank: 4'd0};
		endcase
		return map;
	endfunction

endpackage

// ==== bbc_glue_top.sv ====
module bbc_glue_top #(
	parameter int ROM_WORDS = bbc_glue_pkg::DEF_ROM_WORDS,
	parameter int RAM_DEPTH = bbc_glue_pkg::DEF_RAM_DEPTH
) (
	input logic clk_sys,
	input logic rst_n,
	input logic core_reset,
	input logic reset_req,
	input logic model_sel,
	input logic load_wr,
	input bbc_glue_pkg::rom_waddr_t load_addr,
	input bbc_glue_pkg::rom_word_t load_data,
	input logic mem_we_n,
	input bbc_glue_pkg::mem_addr_t mem_addr,
	input bbc_glue_pkg::mem_byte_t mem_wdata,
	input logic mouse_stb,
	input bbc_glue_pkg::axis_t mouse_dx,
	input bbc_glue_pkg::axis_t mouse_dy,
	input logic [1:0] mouse_btn,
	input logic mouse_en,
	input logic joy_active,
	input logic [7:0] joy1_x,
	input logic [7:0] joy1_y,
	input logic [7:0] joy2_x,
	input logic [7:0] joy2_y,
	input logic joy1_fire,
	input logic joy2_fire,
	input logic swap,
	output bbc_glue_pkg::mem_byte_t mem_rdata,
	output logic model_m128,
	output bbc_glue_pkg::stick_t stick1_x,
	output bbc_glue_pkg::stick_t stick1_y,
	output bbc_glue_pkg::stick_t stick2_x,
	output bbc_glue_pkg::stick_t stick2_y,
	output logic stick1_fire_n,
	output logic stick2_fire_n
);

	logic mouse_step;
	logic mouse_clear;
	logic emu_on;
	bbc_glue_pkg::axis_t axis_x;
	bbc_glue_pkg::axis_t axis_y;

	// core memory bus between ctrl and the banks
	mem_if bus ();

	//==========================================================================
	// memory side
	//==========================================================================

	glue_ctrl u_ctrl (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.reset_req(reset_req),
		.model_sel(model_sel),
		.mem_we_n(mem_we_n),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mouse_stb(mouse_stb),
		.mouse_en(mouse_en),
		.joy_active(joy_active),
		.mem(bus.ctrl),
		.mem_rdata(mem_rdata),
		.model_m128(model_m128),
		.mouse_step(mouse_step),
		.mouse_clear(mouse_clear),
		.emu_on(emu_on)
	);

	rom_bank #(.ROM_WORDS(ROM_WORDS)) u_rom (
		.clk_sys(clk_sys),
		.core_reset(core_reset),
		.load_wr(load_wr),
		.load_addr(load_addr),
		.load_data(load_data),
		.mem(bus.rom)
	);

	ram_bank #(.RAM_DEPTH(RAM_DEPTH)) u_ram (
		.clk_sys(clk_sys),
		.mem(bus.ram)
	);

	//==========================================================================
	// analog joystick side
	//==========================================================================

	mouse_axis u_axis (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.mouse_step(mouse_step),
		.mouse_clear(mouse_clear),
		.mouse_dx(mouse_dx),
		.mouse_dy(mouse_dy),
		.axis_x(axis_x),
		.axis_y(axis_y)
	);

	stick_route u_route (
		.emu_on(emu_on),
		.axis_x(axis_x),
		.axis_y(axis_y),
		.mouse_btn(mouse_btn),
		.joy1_x(joy1_x),
		.joy1_y(joy1_y),
		.joy1_fire(joy1_fire),
		.joy2_x(joy2_x),
		.joy2_y(joy2_y),
		.joy2_fire(joy2_fire),
		.swap(swap),
		.stick1_x(stick1_x),
		.stick1_y(stick1_y),
		.stick2_x(stick2_x),
		.stick2_y(stick2_y),
		.stick1_fire_n(stick1_fire_n),
		.stick2_fire_n(stick2_fire_n)
	);

endmodule

// ==== flist.f ====
bbc_glue_pkg.sv
mem_if.sv
glue_ctrl.sv
rom_bank.sv
ram_bank.sv
mouse_axis.sv
stick_route.sv
bbc_glue_top.sv
tb_bbc_glue.sv

// ==== glue_ctrl.sv ====
module glue_ctrl (
	input logic clk_sys,
	input logic rst_n,
	input logic reset_req,
	input logic model_sel,
	input logic mem_we_n,
	input bbc_glue_pkg::mem_addr_t mem_addr,
	input bbc_glue_pkg::mem_byte_t mem_wdata,
	input logic mouse_stb,
	input logic mouse_en,
	input logic joy_active,
	mem_if.ctrl mem,
	output bbc_glue_pkg::mem_byte_t mem_rdata,
	output logic model_m128,
	output logic mouse_step,
	output logic mouse_clear,
	output logic emu_on
);

	// previous strobe levels
	logic we_q;
	logic stb_q;

	//==========================================================================
	// core bus
	//==========================================================================

	assign mem.addr = mem_addr;
	assign mem.wdata = mem_wdata;
	assign mem.m128 = model_m128;

	// falling edge of write enable, ram space only
	assign mem.wr_pulse = we_q & ~mem_we_n & mem_addr[18];

	// read data follows the live address
	assign mem_rdata = mem_addr[18] ? mem.ram_rdata : mem.rom_rdata;

	//==========================================================================
	// mouse strobe and emulation flag
	//==========================================================================

	// any toggle is one report
	assign mouse_step = mouse_stb ^ stb_q;
	// real stick, core reset or mouse off drops emulation
	assign mouse_clear = joy_active | reset_req | ~mouse_en;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			we_q <= 1'b1;
			stb_q <= 1'b0;
			model_m128 <= 1'b0;
			emu_on <= 1'b0;
		end else begin
			we_q <= mem_we_n;
			stb_q <= mouse_stb;
			// model only changes while the core asks for reset
			if (reset_req) begin
				model_m128 <= model_sel;
			end
			// clear wins over a step in the same cycle
			if (mouse_clear) begin
				emu_on <= 1'b0;
			end else if (mouse_step) begin
				emu_on <= 1'b1;
			end
		end
	end

endmodule

// ==== mem_if.sv ====
interface mem_if;

	// core address, held by the core for the whole access
	bbc_glue_pkg::mem_addr_t addr;
	// latched model, 1 = master
	logic m128;
	// one cycle, already gated to ram space
	logic wr_pulse;
	bbc_glue_pkg::mem_byte_t wdata;

	// byte from rom side, zero for empty slot
	bbc_glue_pkg::mem_byte_t rom_rdata;
	// registered ram byte
	bbc_glue_pkg::mem_byte_t ram_rdata;

	modport ctrl (
		output addr,
		output m128,
		output wr_pulse,
		output wdata,
		input rom_rdata,
		input ram_rdata
	);

	modport rom (
		input addr,
		input m128,
		output rom_rdata
	);

	modport ram (
		input addr,
		input wr_pulse,
		input wdata,
		output ram_rdata
	);

endinterface

// ==== mouse_axis.sv ====
module mouse_axis (
	input logic clk_sys,
	input logic rst_n,
	input logic mouse_step,
	input logic mouse_clear,
	input bbc_glue_pkg::axis_t mouse_dx,
	input bbc_glue_pkg::axis_t mouse_dy,
	output bbc_glue_pkg::axis_t axis_x,
	output bbc_glue_pkg::axis_t axis_y
);

	// clamped deltas
	bbc_glue_pkg::axis_t dx_c;
	bbc_glue_pkg::axis_t dy_c;
	// next axis values after saturation
	bbc_glue_pkg::axis_t nx;
	bbc_glue_pkg::axis_t ny;

	// saturate to [lo, hi]
	function automatic bbc_glue_pkg::axis_t sat(input int v, input int lo, input int hi);
		if (v < lo) begin
			return bbc_glue_pkg::axis_t'(lo);
		end
		if (v > hi) begin
			return bbc_glue_pkg::axis_t'(hi);
		end
		return bbc_glue_pkg::axis_t'(v);
	endfunction

	always_comb begin
		dx_c = sat(int'(mouse_dx), -bbc_glue_pkg::MOUSE_STEP_MAX, bbc_glue_pkg::MOUSE_STEP_MAX);
		dy_c = sat(int'(mouse_dy), -bbc_glue_pkg::MOUSE_STEP_MAX, bbc_glue_pkg::MOUSE_STEP_MAX);
		// mouse y grows upward, stick y grows downward
		nx = sat(int'(axis_x) + int'(dx_c), bbc_glue_pkg::AXIS_MIN, bbc_glue_pkg::AXIS_MAX);
		ny = sat(int'(axis_y) - int'(dy_c), bbc_glue_pkg::AXIS_MIN, bbc_glue_pkg::AXIS_MAX);
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			axis_x <= '0;
			axis_y <= '0;
		end else if (mouse_clear) begin
			// back to centre when emulation drops
			axis_x <= '0;
			axis_y <= '0;
		end else if (mouse_step) begin
			axis_x <= nx;
			axis_y <= ny;
		end
	end

endmodule

// ==== ram_bank.sv ====
module ram_bank #(
	parameter int RAM_DEPTH = bbc_glue_pkg::DEF_RAM_DEPTH
) (
	input logic clk_sys,
	mem_if.ram mem
);

	bbc_glue_pkg::mem_byte_t ram [RAM_DEPTH];
	logic [17:0] ram_addr;

	// sideways, shadow and main ram share one array
	assign ram_addr = mem.addr[17:0];

	// write on the pulse, read every cycle
	always_ff @(posedge clk_sys) begin
		if (mem.wr_pulse) begin
			ram[ram_addr] <= mem.wdata;
		end
		mem.ram_rdata <= ram[ram_addr];
	end

endmodule

// ==== rom_bank.sv ====
module rom_bank #(
	parameter int ROM_WORDS = bbc_glue_pkg::DEF_ROM_WORDS
) (
	input logic clk_sys,
	input logic core_reset,
	input logic load_wr,
	input bbc_glue_pkg::rom_waddr_t load_addr,
	input bbc_glue_pkg::rom_word_t load_data,
	mem_if.rom mem
);

	bbc_glue_pkg::rom_word_t rom [ROM_WORDS];
	bbc_glue_pkg::rom_word_t rom_q;
	bbc_glue_pkg::rom_waddr_t rd_addr;
	bbc_glue_pkg::rom_map_t map;
	logic [bbc_glue_pkg::ROM_SLOT_BITS-1:0] slot;

	//==========================================================================
	// slot mapping
	//==========================================================================

	assign slot = mem.addr[17:14];
	assign map = bbc_glue_pkg::rom_bank_of(mem.m128, slot);

	// bank picks the 8K word page, addr 13:1 the word inside it
	assign rd_addr = {map.bank, mem.addr[13:1]};

	//==========================================================================
	// storage
	//==========================================================================

	// loader only writes while the core sits in reset
	always_ff @(posedge clk_sys) begin
		if (load_wr && core_reset) begin
			rom[load_addr] <= load_data;
		end
	end

	// one register stage on the read side
	always_ff @(posedge clk_sys) begin
		rom_q <= rom[rd_addr];
	end

	//==========================================================================
	// byte select
	//==========================================================================

	// odd address takes the low byte
	// valid and byte lane come from the live address
	always_comb begin
		if (!map.valid) begin
			mem.rom_rdata = '0;
		end else if (mem.addr[0]) begin
			mem.rom_rdata = rom_q[7:0];
		end else begin
			mem.rom_rdata = rom_q[15:8];
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_bbc_glue -f flist.f -o sim_bbc_glue
./obj_dir/sim_bbc_glue | tee sim.log

if grep -q "Test FAILED" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation passed"

// ==== stick_route.sv ====
module stick_route (
	input logic emu_on,
	input bbc_glue_pkg::axis_t axis_x,
	input bbc_glue_pkg::axis_t axis_y,
	input logic [1:0] mouse_btn,
	input logic [7:0] joy1_x,
	input logic [7:0] joy1_y,
	input logic joy1_fire,
	input logic [7:0] joy2_x,
	input logic [7:0] joy2_y,
	input logic joy2_fire,
	input logic swap,
	output bbc_glue_pkg::stick_t stick1_x,
	output bbc_glue_pkg::stick_t stick1_y,
	output bbc_glue_pkg::stick_t stick2_x,
	output bbc_glue_pkg::stick_t stick2_y,
	output logic stick1_fire_n,
	output logic stick2_fire_n
);

	// source a, mouse or joy1
	logic [7:0] a_x;
	logic [7:0] a_y;
	logic a_fire;
	bbc_glue_pkg::stick_t ca_x;
	bbc_glue_pkg::stick_t ca_y;
	bbc_glue_pkg::stick_t cb_x;
	bbc_glue_pkg::stick_t cb_y;

	// signed centre-zero to inverted offset binary, then 8 to 12 bits
	function automatic bbc_glue_pkg::stick_t to_stick(input logic [7:0] v);
		logic [7:0] t;
		t = 8'hff - {~v[7], v[6:0]};
		return {t, t[7:4]};
	endfunction

	assign a_x = emu_on ? axis_x[7:0] : joy1_x;
	assign a_y = emu_on ? axis_y[7:0] : joy1_y;
	// either mouse button fires
	assign a_fire = emu_on ? |mouse_btn : joy1_fire;

	assign ca_x = to_stick(a_x);
	assign ca_y = to_stick(a_y);
	assign cb_x = to_stick(joy2_x);
	assign cb_y = to_stick(joy2_y);

	// swap exchanges whole channels, fire included
	assign stick1_x = swap ? cb_x : ca_x;
	assign stick1_y = swap ? cb_y : ca_y;
	assign stick2_x = swap ? ca_x : cb_x;
	assign stick2_y = swap ? ca_y : cb_y;
	// core expects fire active low
	assign stick1_fire_n = ~(swap ? joy2_fire : a_fire);
	assign stick2_fire_n = ~(swap ? a_fire : joy2_fire);

endmodule

// ==== tb_bbc_glue.sv ====
module tb_bbc_glue;

	localparam int RAM_SPAN = bbc_glue_pkg::DEF_RAM_DEPTH;
	localparam int WATCHDOG_CYCLES = 20000;

	logic clk_sys;
	logic rst_n;
	logic core_reset;
	logic reset_req;
	logic model_sel;
	logic load_wr;
	bbc_glue_pkg::rom_waddr_t load_addr;
	bbc_glue_pkg::rom_word_t load_data;
	logic mem_we_n;
	bbc_glue_pkg::mem_addr_t mem_addr;
	bbc_glue_pkg::mem_byte_t mem_wdata;
	logic mouse_stb;
	bbc_glue_pkg::axis_t mouse_dx;
	bbc_glue_pkg::axis_t mouse_dy;
	logic [1:0] mouse_btn;
	logic mouse_en;
	logic joy_active;
	logic [7:0] joy1_x;
	logic [7:0] joy1_y;
	logic [7:0] joy2_x;
	logic [7:0] joy2_y;
	logic joy1_fire;
	logic joy2_fire;
	logic swap;
	bbc_glue_pkg::mem_byte_t mem_rdata;
	logic model_m128;
	bbc_glue_pkg::stick_t stick1_x;
	bbc_glue_pkg::stick_t stick1_y;
	bbc_glue_pkg::stick_t stick2_x;
	bbc_glue_pkg::stick_t stick2_y;
	logic stick1_fire_n;
	logic stick2_fire_n;

	// populated rom slots per model, index gives bank order
	int b_slots[4] = '{4, 8, 14, 15};
	int m_slots[10] = '{2, 3, 4, 9, 10, 11, 12, 13, 14, 15};
	// shadow memories
	logic [15:0] rom_ref [int];
	logic [7:0] ram_ref [int];
	// model of the mouse path and model latch
	int ax;
	int ay;
	bit emu;
	bit model_exp;
	int checks;
	int errors;

	bbc_glue_top uut (.*);

	always #10 clk_sys = ~clk_sys;

	// one cycle, inputs change 2 units after the edge
	task automatic tick();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic check_eq(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("error at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic report(input string name, input int chk0, input int err0);
		$display("%s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
	endtask

	function automatic int bank_for(input bit m, input int slot);
		if (m) begin
			for (int k = 0; k < 10; k++) begin
				if (m_slots[k] == slot) return 4 + k;
			end
		end else begin
			for (int k = 0; k < 4; k++) begin
				if (b_slots[k] == slot) return k;
			end
		end
		return -1;
	endfunction

	function automatic int clampi(input int v, input int lo, input int hi);
		if (v < lo) return lo;
		if (v > hi) return hi;
		return v;
	endfunction

	// offset binary flipped, then top nibble repeated below
	function automatic int conv(input int v);
		int t;
		t = 255 - ((v & 255) ^ 128);
		return (t << 4) | (t >> 4);
	endfunction

	task automatic check_sticks();
		int a_x;
		int a_y;
		int a_f;
		a_x = emu ? (ax & 255) : int'(joy1_x);
		a_y = emu ? (ay & 255) : int'(joy1_y);
		a_f = emu ? int'(mouse_btn != 2'b00) : int'(joy1_fire);
		check_eq("stick1_x", int'(stick1_x), swap ? conv(int'(joy2_x)) : conv(a_x));
		check_eq("stick1_y", int'(stick1_y), swap ? conv(int'(joy2_y)) : conv(a_y));
		check_eq("stick2_x", int'(stick2_x), swap ? conv(a_x) : conv(int'(joy2_x)));
		check_eq("stick2_y", int'(stick2_y), swap ? conv(a_y) : conv(int'(joy2_y)));
		check_eq("stick1_fire_n", int'(stick1_fire_n), swap ? int'(!joy2_fire) : int'(a_f == 0));
		check_eq("stick2_fire_n", int'(stick2_fire_n), swap ? int'(a_f == 0) : int'(!joy2_fire));
	endtask

	// latch goes through reset_req, which also drops emulation
	task automatic latch_model(input bit m);
		int n;
		model_sel = m;
		reset_req = 1'b1;
		tick();
		reset_req = 1'b0;
		n = 0;
		while (model_m128 !== m && n < 8) begin
			tick();
			n++;
		end
		if (model_m128 !== m) begin
			$display("timeout: model_m128 never took the value %0d", m);
			$display("Test FAILED");
			$finish;
		end
		model_exp = m;
		ax = 0;
		ay = 0;
		emu = 1'b0;
	endtask

	task automatic read_check(input logic [18:0] a, input int exp, input string what);
		mem_addr = a;
		tick();
		tick();
		check_eq(what, int'(mem_rdata), exp);
	endtask

	task automatic write_ram(input logic [18:0] a, input logic [7:0] d);
		mem_addr = a;
		mem_wdata = d;
		mem_we_n = 1'b0;
		tick();
		mem_we_n = 1'b1;
		tick();
	endtask

	// one mouse report, then update the accumulator model
	task automatic step_mouse(input int dx, input int dy);
		mouse_stb = ~mouse_stb;
		mouse_dx = bbc_glue_pkg::axis_t'(dx);
		mouse_dy = bbc_glue_pkg::axis_t'(dy);
		tick();
		ax = clampi(ax + clampi(dx, -10, 10), -128, 127);
		ay = clampi(ay - clampi(dy, -10, 10), -128, 127);
		emu = 1'b1;
	endtask

	// kind 0 joy_active, 1 mouse_en low, 2 reset_req pulse
	task automatic clear_by(input int kind);
		joy_active = (kind == 0);
		mouse_en = (kind != 1);
		reset_req = (kind == 2);
		model_sel = model_exp;
		tick();
		ax = 0;
		ay = 0;
		emu = 1'b0;
		check_sticks();
		joy_active = 1'b0;
		mouse_en = 1'b1;
		reset_req = 1'b0;
	endtask

	// ========================================================================
	// watchdog
	// ========================================================================

	initial begin
		int n;
		n = 0;
		while (n < WATCHDOG_CYCLES) begin
			@(posedge clk_sys);
			n++;
		end
		$display("timeout: simulation ran past %0d cycles", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	// ========================================================================
	// stimulus
	// ========================================================================

	initial begin
		int m;
		int slot;
		int off;
		int waddr;
		int first_waddr;
		int ra;
		int d;
		int dir;
		int chk0;
		int err0;
		logic [18:0] a;
		logic [18:0] bq[$];
		logic [18:0] mq[$];
		int wq[$];
		clk_sys = 1'b0;
		rst_n = 1'b0;
		core_reset = 1'b1;
		reset_req = 1'b0;
		model_sel = 1'b0;
		load_wr = 1'b0;
		load_addr = '0;
		load_data = '0;
		mem_we_n = 1'b1;
		mem_addr = '0;
		mem_wdata = '0;
		mouse_stb = 1'b0;
		mouse_dx = '0;
		mouse_dy = '0;
		mouse_btn = 2'b00;
		mouse_en = 1'b1;
		joy_active = 1'b0;
		joy1_x = 8'h00;
		joy1_y = 8'h00;
		joy2_x = 8'h00;
		joy2_y = 8'h00;
		joy1_fire = 1'b0;
		joy2_fire = 1'b0;
		swap = 1'b0;
		ax = 0;
		ay = 0;
		emu = 1'b0;
		model_exp = 1'b0;
		checks = 0;
		errors = 0;
		first_waddr = 0;
		void'($urandom(32'ha2e6_43f2));
		repeat (8) @(posedge clk_sys);
		#2;
		rst_n = 1'b1;
		tick();

		// rom load under core_reset, random slots of both models
		chk0 = checks;
		err0 = errors;
		for (int i = 0; i < 64; i++) begin
			m = int'($urandom_range(0, 1));
			slot = (m != 0) ? m_slots[$urandom_range(0, 9)] : b_slots[$urandom_range(0, 3)];
			off = int'($urandom_range(0, 16383));
			a = {1'b0, 4'(slot), 14'(off)};
			waddr = bank_for(m != 0, slot) * 8192 + off / 2;
			if (i == 0) first_waddr = waddr;
			load_wr = 1'b1;
			load_addr = 17'(waddr);
			load_data = 16'($urandom);
			rom_ref[waddr] = load_data;
			tick();
			if (m != 0) mq.push_back(a);
			else bq.push_back(a);
		end
		load_wr = 1'b0;
		core_reset = 1'b0;
		tick();
		// loader is ignored once the core runs
		load_wr = 1'b1;
		load_addr = 17'(first_waddr);
		load_data = ~rom_ref[first_waddr];
		tick();
		load_wr = 1'b0;
		for (int mm = 0; mm < 2; mm++) begin
			latch_model(mm != 0);
			for (int j = 0; j < ((mm != 0) ? mq.size() : bq.size()); j++) begin
				a = (mm != 0) ? mq[j] : bq[j];
				waddr = bank_for(mm != 0, int'(a[17:14])) * 8192 + int'(a[13:1]);
				read_check(a, a[0] ? int'(rom_ref[waddr][7:0]) : int'(rom_ref[waddr][15:8]),
					"rom byte");
			end
			// every empty slot reads zero
			for (int s = 0; s < 16; s++) begin
				if (bank_for(mm != 0, s) < 0) begin
					read_check({1'b0, 4'(s), 14'($urandom)}, 0, "empty rom slot");
				end
			end
		end
		report("rom load and mapping", chk0, err0);

		// ram writes, some aimed at rom space with the same low bits
		chk0 = checks;
		err0 = errors;
		for (int i = 0; i < 48; i++) begin
			ra = int'($urandom_range(0, RAM_SPAN - 1));
			d = int'($urandom_range(0, 255));
			write_ram({1'b1, 18'(ra)}, 8'(d));
			ram_ref[ra] = 8'(d);
			wq.push_back(ra);
			if ($urandom_range(0, 1) == 1) write_ram({1'b0, 18'(ra)}, ~8'(d));
		end
		foreach (wq[j]) begin
			read_check({1'b1, 18'(wq[j])}, int'(ram_ref[wq[j]]), "ram byte");
		end
		report("ram writes", chk0, err0);

		// model only moves while reset_req is high
		chk0 = checks;
		err0 = errors;
		model_sel = ~model_exp;
		for (int i = 0; i < 3; i++) begin
			tick();
			check_eq("model_m128 held", int'(model_m128), int'(model_exp));
		end
		reset_req = 1'b1;
		tick();
		model_exp = ~model_exp;
		check_eq("model_m128 latched", int'(model_m128), int'(model_exp));
		reset_req = 1'b0;
		model_sel = ~model_exp;
		tick();
		check_eq("model_m128 held", int'(model_m128), int'(model_exp));
		model_sel = model_exp;
		report("model latch", chk0, err0);

		// mouse walk, pushed one way then back to hit both limits
		chk0 = checks;
		err0 = errors;
		for (int i = 0; i < 160; i++) begin
			dir = (((i / 40) % 2) == 0) ? 1 : -1;
			mouse_btn = 2'($urandom);
			swap = 1'($urandom);
			// joy1 keeps moving so the two sources differ
			joy1_x = 8'($urandom);
			joy1_y = 8'($urandom);
			joy1_fire = 1'($urandom);
			joy2_x = 8'($urandom);
			joy2_y = 8'($urandom);
			if ($urandom_range(0, 3) == 0) begin
				tick();
			end else begin
				step_mouse(dir * int'($urandom_range(0, 255)),
					-dir * int'($urandom_range(0, 255)));
			end
			check_sticks();
		end
		for (int k = 0; k < 3; k++) begin
			for (int i = 0; i < 3; i++) begin
				step_mouse(int'($urandom_range(0, 511)) - 256,
					int'($urandom_range(0, 511)) - 256);
			end
			clear_by(k);
			// axes restart from centre
			step_mouse(int'($urandom_range(0, 511)) - 256,
				int'($urandom_range(0, 511)) - 256);
			check_sticks();
		end
		clear_by(0);
		report("mouse accumulation", chk0, err0);

		// joystick path with emulation off
		chk0 = checks;
		err0 = errors;
		for (int i = 0; i < 40; i++) begin
			joy1_x = 8'($urandom);
			joy1_y = 8'($urandom);
			joy2_x = 8'($urandom);
			joy2_y = 8'($urandom);
			joy1_fire = 1'($urandom);
			joy2_fire = 1'($urandom);
			swap = 1'($urandom);
			tick();
			check_sticks();
		end
		report("stick conversion and swap", chk0, err0);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
